//--- project.f
hw/glb_pkg.sv
hw/glb_mem_ifc.sv
hw/glb_bank.sv
hw/glb_core_switch.sv
hw/glb_dma_ctrl.sv
hw/glb_dma_addr_counter.sv
hw/glb_dma_datapath.sv
hw/glb_core.sv
tb/glb_core_tb.sv

//--- tb/glb_core_tb.sv
// Global buffer tile core testbench
// Processor traffic, store and load DMA transfers against a reference memory.
// Concurrent assertions on the rising edge do all the checking
`timescale 1ns/1ps

module glb_core_tb;
    import glb_pkg::*;

    localparam int AW          = GLB_ADDR_WIDTH;
    localparam int DW          = CGRA_DATA_WIDTH;
    localparam int XFER_WORDS  = 24;
    localparam int ST_BASE     = 512;
    localparam int LD_BASE     = 768;
    // Three transfers of XFER_WORDS each
    localparam int CYCLE_LIMIT = 4 * (3 * XFER_WORDS) + 200;

    logic          clk, rst;
    logic          proc_wr_en, proc_rd_en, proc_rd_data_valid;
    logic [AW-1:0] proc_wr_addr, proc_rd_addr;
    logic [DW-1:0] proc_wr_data, proc_rd_data;
    logic [DW-1:0] stream_data_f2g, stream_data_g2f;
    logic          stream_data_valid_f2g, stream_data_valid_g2f;
    logic [AW-1:0] cfg_st_start_addr, cfg_st_num_words;
    logic [AW-1:0] cfg_ld_start_addr, cfg_ld_num_words;
    logic          st_start_pulse, ld_start_pulse;
    logic          strm_f2g_interrupt_pulse, strm_g2f_interrupt_pulse, dma_busy;

    // Reference model of all banks
    logic [DW-1:0] ref_mem [2**AW];
    // Expected load stream, in address order across loads
    logic [DW-1:0] ld_exp [64];
    logic [DW-1:0] ld_exp_word;
    int            ld_idx = 0;
    int            ld_total = 0;
    // Expected processor read word, delayed by the read latency
    logic [DW-1:0] exp_proc_word, exp_rd_d1, exp_rd_d2;
    logic          st_last_word, start_ok;
    logic [15:0]   lfsr_state;
    int            cycle_cnt = 0;
    int            err_cnt = 0;

    glb_core #(
        .NUM_BANKS  (2 ** BANK_SEL_WIDTH),
        .BANK_DEPTH (2 ** BANK_ADDR_WIDTH)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign ld_exp_word = ld_exp[ld_idx];
    // A start the controller must accept when idle
    assign start_ok = (st_start_pulse && cfg_st_num_words != '0) ||
                      (ld_start_pulse && cfg_ld_num_words != '0);

    always @(posedge clk) begin
        exp_rd_d1 <= exp_proc_word;
        exp_rd_d2 <= exp_rd_d1;
        if (stream_data_valid_g2f) begin
            ld_idx <= ld_idx + 1;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout, run went past %0d cycles", CYCLE_LIMIT);
            report_failure();
        end
    end

    // 16-bit Galois LFSR, one step per bit
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic report_failure();
        err_cnt++;
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    function automatic void clear_strobes();
        proc_wr_en            = 1'b0;
        proc_rd_en            = 1'b0;
        stream_data_valid_f2g = 1'b0;
        st_last_word          = 1'b0;
        st_start_pulse        = 1'b0;
        ld_start_pulse        = 1'b0;
    endfunction

    // Each task below takes one cycle
    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            clear_strobes();
        end
    endtask

    task automatic proc_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
        @(negedge clk);
        clear_strobes();
        proc_wr_en    = 1'b1;
        proc_wr_addr  = addr;
        proc_wr_data  = data;
        ref_mem[addr] = data;
    endtask

    task automatic proc_read(input logic [AW-1:0] addr);
        @(negedge clk);
        clear_strobes();
        proc_rd_en    = 1'b1;
        proc_rd_addr  = addr;
        exp_proc_word = ref_mem[addr];
    endtask

    task automatic stream_word(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                               input logic last);
        @(negedge clk);
        clear_strobes();
        stream_data_valid_f2g = 1'b1;
        stream_data_f2g       = data;
        st_last_word          = last;
        ref_mem[addr]         = data;
    endtask

    task automatic start_store(input logic [AW-1:0] addr, input logic [AW-1:0] num);
        @(negedge clk);
        clear_strobes();
        cfg_st_start_addr = addr;
        cfg_st_num_words  = num;
        st_start_pulse    = 1'b1;
    endtask

    // Expected words queued only when the start should be taken
    task automatic start_load(input logic [AW-1:0] addr, input logic [AW-1:0] num,
                              input logic accepted);
        @(negedge clk);
        clear_strobes();
        cfg_ld_start_addr = addr;
        cfg_ld_num_words  = num;
        ld_start_pulse    = 1'b1;
        if (accepted) begin
            for (int i = 0; i < int'(num); i++) begin
                ld_exp[ld_total + i] = ref_mem[AW'(addr + i)];
            end
            ld_total += int'(num);
        end
    endtask

    reset_idle: assert property (@(posedge clk) rst |=> (!proc_rd_data_valid &&
            !stream_data_valid_g2f && !strm_f2g_interrupt_pulse &&
            !strm_g2f_interrupt_pulse && !dma_busy))
        else begin
            $display("Outputs still active after a reset cycle");
            report_failure();
        end

    rd_latency: assert property (@(posedge clk) disable iff (rst)
            proc_rd_en |-> ##2 proc_rd_data_valid)
        else begin
            $display("proc_rd_data_valid missing two cycles after a processor read");
            report_failure();
        end

    rd_no_extra: assert property (@(posedge clk) disable iff (rst)
            proc_rd_data_valid |-> $past(proc_rd_en, 2))
        else begin
            $display("proc_rd_data_valid without a processor read two cycles before");
            report_failure();
        end

    rd_data: assert property (@(posedge clk) disable iff (rst)
            proc_rd_data_valid |-> proc_rd_data == exp_rd_d2)
        else begin
            $display("Fail proc_rd_data: got 0x%h, expected 0x%h",
                     $sampled(proc_rd_data), $sampled(exp_rd_d2));
            report_failure();
        end

    ld_data: assert property (@(posedge clk) disable iff (rst)
            stream_data_valid_g2f |-> stream_data_g2f == ld_exp_word)
        else begin
            $display("Fail stream_data_g2f: got 0x%h, expected 0x%h",
                     $sampled(stream_data_g2f), $sampled(ld_exp_word));
            report_failure();
        end

    ld_no_extra: assert property (@(posedge clk) disable iff (rst)
            stream_data_valid_g2f |-> ld_idx < ld_total)
        else begin
            $display("Stream output word with no load expecting it");
            report_failure();
        end

    // Last word written one cycle after its valid, interrupt one cycle later
    f2g_irq: assert property (@(posedge clk) disable iff (rst)
            (stream_data_valid_f2g && st_last_word) |-> ##2 strm_f2g_interrupt_pulse)
        else begin
            $display("Store interrupt missing after the last stream word");
            report_failure();
        end

    f2g_irq_only: assert property (@(posedge clk) disable iff (rst)
            strm_f2g_interrupt_pulse |-> $past(stream_data_valid_f2g && st_last_word, 2))
        else begin
            $display("Store interrupt without a finished store");
            report_failure();
        end

    g2f_irq: assert property (@(posedge clk) disable iff (rst)
            (stream_data_valid_g2f && ld_idx + 1 == ld_total) |=> strm_g2f_interrupt_pulse)
        else begin
            $display("Load interrupt missing after the last stream word");
            report_failure();
        end

    g2f_irq_only: assert property (@(posedge clk) disable iff (rst)
            strm_g2f_interrupt_pulse |-> $past(stream_data_valid_g2f && ld_idx + 1 == ld_total))
        else begin
            $display("Load interrupt without a finished load");
            report_failure();
        end

    busy_start: assert property (@(posedge clk) disable iff (rst)
            !dma_busy |=> dma_busy == $past(start_ok))
        else begin
            $display("dma_busy did not follow the start pulse from idle");
            report_failure();
        end

    initial begin
        logic [AW-1:0] wr_addrs [16];
        logic [15:0]   ofs;
        logic [AW-1:0] ld_next;
        lfsr_state        = 16'd59;
        rst               = 1'b1;
        clear_strobes();
        proc_wr_addr      = '0;
        proc_wr_data      = '0;
        proc_rd_addr      = '0;
        stream_data_f2g   = '0;
        cfg_st_start_addr = '0;
        cfg_st_num_words  = '0;
        cfg_ld_start_addr = '0;
        cfg_ld_num_words  = '0;
        exp_proc_word     = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Random processor writes, load region fill, then read back
        for (int i = 0; i < 16; i++) begin
            wr_addrs[i] = AW'(rand_bits(8));
            proc_write(wr_addrs[i], rand_bits(DW));
        end
        for (int i = 0; i < 2 * XFER_WORDS; i++) begin
            proc_write(AW'(LD_BASE + i), rand_bits(DW));
        end
        for (int i = 0; i < 16; i++) begin
            proc_read(wr_addrs[15 - i]);
        end

        // Store with random gaps between valids
        start_store(AW'(ST_BASE), AW'(XFER_WORDS));
        for (int i = 0; i < XFER_WORDS; i++) begin
            idle(int'(rand_bits(2)));
            stream_word(AW'(ST_BASE + i), rand_bits(DW), i == XFER_WORDS - 1);
        end
        do idle(1); while (!strm_f2g_interrupt_pulse);
        for (int i = 0; i < XFER_WORDS; i++) begin
            proc_read(AW'(ST_BASE + i));
        end

        // Load, with starts while busy that must be dropped
        start_load(AW'(LD_BASE), AW'(XFER_WORDS), 1'b1);
        idle(3);
        start_store(AW'(ST_BASE), AW'(8));
        start_load(AW'(LD_BASE + XFER_WORDS), AW'(XFER_WORDS), 1'b0);
        do idle(1); while (!strm_g2f_interrupt_pulse);

        // Load with processor reads aimed at the bank the DMA reads next
        // DMA request address only moves on cycles without a processor read
        ld_next = AW'(LD_BASE + XFER_WORDS);
        start_load(ld_next, AW'(XFER_WORDS), 1'b1);
        while (!strm_g2f_interrupt_pulse) begin
            if (rand_bits(1) != 0) begin
                ofs = rand_bits(4);
                proc_read(AW'(LD_BASE + 2 * ofs + ld_next[0]));
            end else begin
                idle(1);
                ld_next = ld_next + 1'b1;
            end
        end

        // Zero counts from idle
        idle(2);
        start_load(AW'(LD_BASE), '0, 1'b0);
        start_store(AW'(ST_BASE), '0);
        idle(10);

        if (err_cnt == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            report_failure();
        end
    end

endmodule

//--- hw/glb_core.sv
// Global buffer tile core
// Interleaved banks behind a switch shared by the processor port
// and a store/load DMA toward the CGRA fabric
`timescale 1ns/1ps

module glb_core #(
    parameter int NUM_BANKS  = 2 ** glb_pkg::BANK_SEL_WIDTH,
    parameter int BANK_DEPTH = 2 ** glb_pkg::BANK_ADDR_WIDTH
) (
    input  logic                                clk,
    input  logic                                rst,

    // Processor port
    input  logic                                proc_wr_en,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  proc_wr_addr,
    input  logic [glb_pkg::CGRA_DATA_WIDTH-1:0] proc_wr_data,
    input  logic                                proc_rd_en,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  proc_rd_addr,
    output logic [glb_pkg::CGRA_DATA_WIDTH-1:0] proc_rd_data,
    output logic                                proc_rd_data_valid,

    // Fabric streams
    input  logic [glb_pkg::CGRA_DATA_WIDTH-1:0] stream_data_f2g,
    input  logic                                stream_data_valid_f2g,
    output logic [glb_pkg::CGRA_DATA_WIDTH-1:0] stream_data_g2f,
    output logic                                stream_data_valid_g2f,

    // DMA config and control
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  cfg_st_start_addr,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  cfg_st_num_words,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  cfg_ld_start_addr,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  cfg_ld_num_words,
    input  logic                                st_start_pulse,
    input  logic                                ld_start_pulse,
    output logic                                strm_f2g_interrupt_pulse,
    output logic                                strm_g2f_interrupt_pulse,
    output logic                                dma_busy
);
    import glb_pkg::*;

    dma_state_t                state;
    logic [GLB_ADDR_WIDTH-1:0] dma_addr;
    logic                      cnt_load, cnt_step, cnt_last, sel_load, rd_req;

    glb_mem_ifc #(.AWIDTH(GLB_ADDR_WIDTH))  dma_mem ();
    glb_mem_ifc #(.AWIDTH(BANK_ADDR_WIDTH)) bank_mem [NUM_BANKS] ();

    // Banks
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        glb_bank #(.BANK_DEPTH(BANK_DEPTH)) bank_i (.clk, .rst, .mem(bank_mem[b]));
    end

    glb_core_switch #(.NUM_BANKS(NUM_BANKS)) switch_i (
        .clk, .rst,
        .proc_wr_en, .proc_rd_en, .proc_wr_addr, .proc_rd_addr,
        .proc_wr_data, .proc_rd_data, .proc_rd_data_valid,
        .dma  (dma_mem),
        .bank (bank_mem)
    );

    glb_dma_ctrl ctrl_i (
        .clk, .rst, .st_start_pulse, .ld_start_pulse,
        .st_num_zero (cfg_st_num_words == '0),
        .ld_num_zero (cfg_ld_num_words == '0),
        .f2g_valid   (stream_data_valid_f2g),
        .rd_gnt      (dma_mem.rd_gnt),
        .cnt_last, .cnt_load, .cnt_step, .sel_load, .rd_req, .state,
        .strm_f2g_interrupt_pulse, .strm_g2f_interrupt_pulse
    );

    // Config picked by the transfer about to start
    glb_dma_addr_counter counter_i (
        .clk, .rst, .load(cnt_load), .step(cnt_step),
        .start_addr (sel_load ? cfg_ld_start_addr : cfg_st_start_addr),
        .num_words  (sel_load ? cfg_ld_num_words : cfg_st_num_words),
        .addr       (dma_addr),
        .last       (cnt_last)
    );

    glb_dma_datapath datapath_i (
        .clk, .rst, .state, .addr(dma_addr), .rd_req,
        .stream_data_f2g, .stream_data_valid_f2g,
        .stream_data_g2f, .stream_data_valid_g2f,
        .mem (dma_mem)
    );

    assign dma_busy = (state != ST_IDLE);

endmodule

//--- hw/glb_dma_datapath.sv
// DMA datapath
// Turns stream words into bank write requests and DMA read
// responses into the outgoing stream
`timescale 1ns/1ps

module glb_dma_datapath (
    input  logic                                clk,
    input  logic                                rst,
    input  glb_pkg::dma_state_t                 state,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  addr,
    input  logic                                rd_req,
    input  logic [glb_pkg::CGRA_DATA_WIDTH-1:0] stream_data_f2g,
    input  logic                                stream_data_valid_f2g,
    output logic [glb_pkg::CGRA_DATA_WIDTH-1:0] stream_data_g2f,
    output logic                                stream_data_valid_g2f,
    glb_mem_ifc.requester                       mem
);
    import glb_pkg::*;

    // Stream words outside a store are dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            mem.wr_en             <= 1'b0;
            stream_data_valid_g2f <= 1'b0;
        end else begin
            mem.wr_en             <= (state == ST_STORE) && stream_data_valid_f2g;
            stream_data_valid_g2f <= mem.rd_data_valid;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        mem.wr_addr     <= addr;
        mem.wr_data     <= stream_data_f2g;
        stream_data_g2f <= mem.rd_data;
    end

    // Read request straight from the controller and counter
    // held by the switch until granted
    assign mem.rd_en   = rd_req;
    assign mem.rd_addr = addr;

endmodule

//--- hw/glb_dma_addr_counter.sv
// DMA address counter
// Holds the current word address and the words still to move
`timescale 1ns/1ps

module glb_dma_addr_counter (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               load,
    input  logic                               step,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0] start_addr,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0] num_words,
    output logic [glb_pkg::GLB_ADDR_WIDTH-1:0] addr,
    output logic                               last
);
    import glb_pkg::*;

    // Words left, including the current one
    logic [GLB_ADDR_WIDTH-1:0] remain;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr   <= '0;
            remain <= '0;
        end else if (load) begin
            addr   <= start_addr;
            remain <= num_words;
        end else if (step) begin
            // Address wraps at the top of the tile
            addr   <= addr + 1'b1;
            remain <= remain - 1'b1;
        end
    end

    assign last = (remain == GLB_ADDR_WIDTH'(1));

endmodule

//--- hw/glb_dma_ctrl.sv
// Global buffer DMA controller
// Sequences one store or one load transfer at a time and raises
// the end-of-transfer interrupt pulses
`timescale 1ns/1ps

module glb_dma_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                st_start_pulse,
    input  logic                ld_start_pulse,
    input  logic                st_num_zero,
    input  logic                ld_num_zero,
    input  logic                f2g_valid,
    input  logic                rd_gnt,
    input  logic                cnt_last,
    output logic                cnt_load,
    output logic                cnt_step,
    output logic                sel_load,
    output logic                rd_req,
    output glb_pkg::dma_state_t state,
    output logic                strm_f2g_interrupt_pulse,
    output logic                strm_g2f_interrupt_pulse
);
    import glb_pkg::*;

    localparam int DRAIN_W = $clog2(RD_LATENCY + 1);

    logic               st_go, ld_go;
    logic               st_last_q;
    logic [DRAIN_W-1:0] drain_cnt;

    // Store wins a tie, zero counts never start
    assign st_go = st_start_pulse && !st_num_zero;
    assign ld_go = ld_start_pulse && !ld_num_zero && !st_go;

    // Counter takes the load config unless a store starts
    assign sel_load = !st_go;
    assign cnt_load = (state == ST_IDLE) && (st_go || ld_go);
    assign rd_req   = (state == ST_LOAD);

    always_comb begin
        cnt_step = 1'b0;
        if (state == ST_STORE) begin
            cnt_step = f2g_valid;
        end else if (state == ST_LOAD) begin
            cnt_step = rd_gnt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state                    <= ST_IDLE;
            drain_cnt                <= '0;
            st_last_q                <= 1'b0;
            strm_f2g_interrupt_pulse <= 1'b0;
            strm_g2f_interrupt_pulse <= 1'b0;
        end else begin
            // Interrupt follows the write of the last stored word
            st_last_q                <= 1'b0;
            strm_f2g_interrupt_pulse <= st_last_q;
            strm_g2f_interrupt_pulse <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (st_go) begin
                        state <= ST_STORE;
                    end else if (ld_go) begin
                        state <= ST_LOAD;
                    end
                end
                ST_STORE: begin
                    if (f2g_valid && cnt_last) begin
                        state     <= ST_IDLE;
                        st_last_q <= 1'b1;
                    end
                end
                ST_LOAD: begin
                    if (rd_gnt && cnt_last) begin
                        state     <= ST_LOAD_DRAIN;
                        drain_cnt <= DRAIN_W'(RD_LATENCY);
                    end
                end
                // Drain spans RD_LATENCY plus the output register
                ST_LOAD_DRAIN: begin
                    if (drain_cnt == '0) begin
                        state                    <= ST_IDLE;
                        strm_g2f_interrupt_pulse <= 1'b1;
                    end else begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- hw/glb_core_switch.sv
// Global buffer core switch
// Routes processor and DMA accesses to the interleaved banks.
// Store writes beat processor writes, processor reads beat DMA reads,
// and an owner tag per read steers each bank response back
`timescale 1ns/1ps

module glb_core_switch #(
    parameter int NUM_BANKS = 2 ** glb_pkg::BANK_SEL_WIDTH
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                proc_wr_en,
    input  logic                                proc_rd_en,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  proc_wr_addr,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  proc_rd_addr,
    input  logic [glb_pkg::CGRA_DATA_WIDTH-1:0] proc_wr_data,
    output logic [glb_pkg::CGRA_DATA_WIDTH-1:0] proc_rd_data,
    output logic                                proc_rd_data_valid,
    glb_mem_ifc.switch                          dma,
    glb_mem_ifc.requester                       bank [NUM_BANKS]
);
    import glb_pkg::*;

    localparam int LAST = RD_LATENCY - 1;

    // Bank select and offset of each request
    logic [BANK_SEL_WIDTH-1:0]  proc_wr_bank, proc_rd_bank, dma_wr_bank, dma_rd_bank;
    logic [BANK_ADDR_WIDTH-1:0] proc_wr_ofs, proc_rd_ofs, dma_wr_ofs, dma_rd_ofs;

    // Responses gathered out of the interface array
    logic [CGRA_DATA_WIDTH-1:0] bank_rd_data [NUM_BANKS];
    logic                       bank_rd_valid [NUM_BANKS];

    // Owner tags, one pipeline per requester
    logic                       proc_tag_vld [RD_LATENCY];
    logic [BANK_SEL_WIDTH-1:0]  proc_tag_bank [RD_LATENCY];
    logic                       dma_tag_vld [RD_LATENCY];
    logic [BANK_SEL_WIDTH-1:0]  dma_tag_bank [RD_LATENCY];

    assign proc_wr_bank = proc_wr_addr[BANK_SEL_WIDTH-1:0];
    assign proc_rd_bank = proc_rd_addr[BANK_SEL_WIDTH-1:0];
    assign dma_wr_bank  = dma.wr_addr[BANK_SEL_WIDTH-1:0];
    assign dma_rd_bank  = dma.rd_addr[BANK_SEL_WIDTH-1:0];
    assign proc_wr_ofs  = proc_wr_addr[GLB_ADDR_WIDTH-1:BANK_SEL_WIDTH];
    assign proc_rd_ofs  = proc_rd_addr[GLB_ADDR_WIDTH-1:BANK_SEL_WIDTH];
    assign dma_wr_ofs   = dma.wr_addr[GLB_ADDR_WIDTH-1:BANK_SEL_WIDTH];
    assign dma_rd_ofs   = dma.rd_addr[GLB_ADDR_WIDTH-1:BANK_SEL_WIDTH];

    // DMA read loses to a processor read at the same bank
    assign dma.rd_gnt = dma.rd_en && !(proc_rd_en && (proc_rd_bank == dma_rd_bank));

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        logic dma_wr_sel, proc_wr_sel, proc_rd_sel, dma_rd_sel;

        // Processor write dropped on a same-bank store write
        assign dma_wr_sel  = dma.wr_en && (dma_wr_bank == BANK_SEL_WIDTH'(b));
        assign proc_wr_sel = proc_wr_en && (proc_wr_bank == BANK_SEL_WIDTH'(b)) && !dma_wr_sel;
        assign proc_rd_sel = proc_rd_en && (proc_rd_bank == BANK_SEL_WIDTH'(b));
        assign dma_rd_sel  = dma.rd_gnt && (dma_rd_bank == BANK_SEL_WIDTH'(b));

        assign bank[b].wr_en   = dma_wr_sel || proc_wr_sel;
        assign bank[b].wr_addr = dma_wr_sel ? dma_wr_ofs : proc_wr_ofs;
        assign bank[b].wr_data = dma_wr_sel ? dma.wr_data : proc_wr_data;
        assign bank[b].rd_en   = proc_rd_sel || dma_rd_sel;
        assign bank[b].rd_addr = proc_rd_sel ? proc_rd_ofs : dma_rd_ofs;

        assign bank_rd_data[b]  = bank[b].rd_data;
        assign bank_rd_valid[b] = bank[b].rd_data_valid;
    end

    // Tag valids, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RD_LATENCY; i++) begin
                proc_tag_vld[i] <= 1'b0;
                dma_tag_vld[i]  <= 1'b0;
            end
        end else begin
            proc_tag_vld[0] <= proc_rd_en;
            dma_tag_vld[0]  <= dma.rd_gnt;
            for (int i = 1; i < RD_LATENCY; i++) begin
                proc_tag_vld[i] <= proc_tag_vld[i-1];
                dma_tag_vld[i]  <= dma_tag_vld[i-1];
            end
        end
    end

    // Bank number of each read in flight
    always_ff @(posedge clk) begin
        proc_tag_bank[0] <= proc_rd_bank;
        dma_tag_bank[0]  <= dma_rd_bank;
        for (int i = 1; i < RD_LATENCY; i++) begin
            proc_tag_bank[i] <= proc_tag_bank[i-1];
            dma_tag_bank[i]  <= dma_tag_bank[i-1];
        end
    end

    // Steer responses by tag
    assign proc_rd_data       = bank_rd_data[proc_tag_bank[LAST]];
    assign proc_rd_data_valid = proc_tag_vld[LAST] && bank_rd_valid[proc_tag_bank[LAST]];
    assign dma.rd_data        = bank_rd_data[dma_tag_bank[LAST]];
    assign dma.rd_data_valid  = dma_tag_vld[LAST] && bank_rd_valid[dma_tag_bank[LAST]];

endmodule

//--- hw/glb_bank.sv
// Global buffer SRAM bank
// Synchronous write, read response after RD_LATENCY cycles
`timescale 1ns/1ps

module glb_bank #(
    parameter int BANK_DEPTH = 2 ** glb_pkg::BANK_ADDR_WIDTH
) (
    input  logic       clk,
    input  logic       rst,
    glb_mem_ifc.bank   mem
);
    import glb_pkg::*;

    logic [CGRA_DATA_WIDTH-1:0] mem_array [BANK_DEPTH];

    // Read pipeline, stage 0 samples the array
    logic [CGRA_DATA_WIDTH-1:0] rd_data_pipe [RD_LATENCY];
    logic                       rd_vld_pipe [RD_LATENCY];

    // Write and first read stage
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            mem_array[mem.wr_addr] <= mem.wr_data;
        end
        if (mem.rd_en) begin
            rd_data_pipe[0] <= mem_array[mem.rd_addr];
        end
        for (int i = 1; i < RD_LATENCY; i++) begin
            rd_data_pipe[i] <= rd_data_pipe[i-1];
        end
    end

    // Valid shifts alongside the data
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RD_LATENCY; i++) begin
                rd_vld_pipe[i] <= 1'b0;
            end
        end else begin
            rd_vld_pipe[0] <= mem.rd_en;
            for (int i = 1; i < RD_LATENCY; i++) begin
                rd_vld_pipe[i] <= rd_vld_pipe[i-1];
            end
        end
    end

    assign mem.rd_data       = rd_data_pipe[RD_LATENCY-1];
    assign mem.rd_data_valid = rd_vld_pipe[RD_LATENCY-1];

endmodule

//--- hw/glb_mem_ifc.sv
// Memory request interface
// Carries a write strobe, a read request with grant and the read response
`timescale 1ns/1ps

interface glb_mem_ifc #(
    parameter int AWIDTH = glb_pkg::GLB_ADDR_WIDTH
);
    import glb_pkg::*;

    // Write strobe
    logic                       wr_en;
    logic [AWIDTH-1:0]          wr_addr;
    logic [CGRA_DATA_WIDTH-1:0] wr_data;

    // Read request, taken when rd_en and rd_gnt are both high
    logic                       rd_en;
    logic [AWIDTH-1:0]          rd_addr;
    logic                       rd_gnt;

    // Response, RD_LATENCY cycles after the grant
    logic [CGRA_DATA_WIDTH-1:0] rd_data;
    logic                       rd_data_valid;

    modport requester (
        output wr_en, wr_addr, wr_data, rd_en, rd_addr,
        input  rd_gnt, rd_data, rd_data_valid
    );

    modport switch (
        input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
        output rd_gnt, rd_data, rd_data_valid
    );

    // Banks never refuse a read, so no grant here
    modport bank (
        input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
        output rd_data, rd_data_valid
    );

endinterface

//--- hw/glb_pkg.sv
// Global buffer tile package
// Shared widths, bank split and read latency for the reduced tile core,
// plus the state type of the DMA controller
package glb_pkg;

    // Tile word address and CGRA data word
    localparam int GLB_ADDR_WIDTH  = 10;
    localparam int CGRA_DATA_WIDTH = 16;

    // Low address bits pick the bank, so words interleave
    localparam int BANK_SEL_WIDTH  = 1;
    localparam int BANK_ADDR_WIDTH = GLB_ADDR_WIDTH - BANK_SEL_WIDTH;

    // Granted read to response, in cycles
    localparam int RD_LATENCY      = 2;

    // DMA controller state
    // Load drain waits for in-flight read responses
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STORE,
        ST_LOAD,
        ST_LOAD_DRAIN
    } dma_state_t;

endpackage
